//--- verilog/ni_rd_pkg.sv
package ni_rd_pkg;

  ////////////////////
  // geometry

  // window side, radius 2 around the centre
  localparam int WIN     = 5;
  localparam int NUM_DIR = 8;

  ////////////////////
  // data types

  typedef logic [7:0]  pixel_t;
  // 25 x 255 fits in 13 bits
  typedef logic [12:0] patch_sum_t;
  typedef logic [3:0]  riu2_code_t;

  // gain on the outer average instead of dividing the patch sum
  localparam patch_sum_t PATCH_AREA      = 13'd25;
  localparam riu2_code_t RIU2_NONUNIFORM = 4'd9;

  // one window column, px[0] is the oldest row
  typedef struct packed {
    pixel_t [WIN-1:0] px;
  } win_col_t;

  // four samples each for the inner and outer ring of one direction
  typedef struct packed {
    pixel_t [3:0] inner;
    pixel_t [3:0] outer;
  } dir_quads_t;

endpackage

//--- verilog/line_buffer.sv
module line_buffer #(
  parameter int IMG_W = 8,
  parameter int IMG_H = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  ni_rd_pkg::pixel_t   pixel_i,
  input  logic                pixel_valid_i,
  output ni_rd_pkg::win_col_t col_o,
  output logic                col_valid_o,
  output logic                win_full_o
);
  import ni_rd_pkg::*;

  localparam int CW    = $clog2(IMG_W);
  localparam int RW    = $clog2(IMG_H);
  localparam int LINES = WIN - 1;

  pixel_t        line_q [LINES][IMG_W];
  logic [CW-1:0] col_cnt;
  logic [RW-1:0] row_cnt;
  logic          col_last;
  logic          row_last;
  logic          in_window;

  assign col_last  = (col_cnt == CW'(IMG_W - 1));
  assign row_last  = (row_cnt == RW'(IMG_H - 1));
  assign in_window = (row_cnt >= RW'(WIN - 1)) && (col_cnt >= CW'(WIN - 1));

  // each line delays by one image row, line r feeds line r+1
  always_ff @(posedge clk) begin
    if (pixel_valid_i) begin
      for (int r = 0; r < LINES; r++) begin
        for (int j = IMG_W - 1; j > 0; j--) begin
          line_q[r][j] <= line_q[r][j-1];
        end
      end
      line_q[0][0] <= pixel_i;
      for (int r = 1; r < LINES; r++) begin
        line_q[r][0] <= line_q[r-1][IMG_W-1];
      end
      col_o.px[WIN-1] <= pixel_i;
      for (int r = 0; r < LINES; r++) begin
        col_o.px[LINES-1-r] <= line_q[r][IMG_W-1];
      end
    end
  end

  ////////////////////
  // raster position, wraps at end of frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt     <= '0;
      row_cnt     <= '0;
      col_valid_o <= 1'b0;
      win_full_o  <= 1'b0;
    end else begin
      col_valid_o <= pixel_valid_i;
      win_full_o  <= pixel_valid_i && in_window;
      if (pixel_valid_i) begin
        if (col_last) begin
          col_cnt <= '0;
          row_cnt <= row_last ? '0 : row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/window_sampler.sv
module window_sampler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ni_rd_pkg::win_col_t   col_i,
  input  logic                  col_valid_i,
  input  logic                  win_full_i,
  output ni_rd_pkg::dir_quads_t quads_o [ni_rd_pkg::NUM_DIR],
  output ni_rd_pkg::patch_sum_t sum_o,
  output logic                  sample_valid_o
);
  import ni_rd_pkg::*;

  localparam int C = WIN / 2;
  // row and column step per direction, counter-clockwise from east
  localparam int DR [NUM_DIR] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int DC [NUM_DIR] = '{1, 1, 0, -1, -1, -1, 0, 1};

  // win_q[col].px[row], column 0 is the oldest
  win_col_t   win_q [WIN];
  win_col_t   win_d [WIN];
  patch_sum_t sum_d;

  always_comb begin
    for (int c = 0; c < WIN - 1; c++) begin
      win_d[c] = win_q[c+1];
    end
    win_d[WIN-1] = col_i;
  end

  // sum over the window as it will be after the shift
  always_comb begin
    sum_d = '0;
    for (int c = 0; c < WIN; c++) begin
      for (int r = 0; r < WIN; r++) begin
        sum_d = sum_d + patch_sum_t'(win_d[c].px[r]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_q          <= '{default: '0};
      sum_o          <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= col_valid_i & win_full_i;
      if (col_valid_i) begin
        win_q <= win_d;
        sum_o <= sum_d;
      end
    end
  end

  ////////////////////
  // fixed sampling positions
  for (genvar k = 0; k < NUM_DIR; k++) begin : g_dir
    localparam int R1 = C + DR[k];
    localparam int C1 = C + DC[k];
    localparam int R2 = C + 2 * DR[k];
    localparam int C2 = C + 2 * DC[k];

    if (DR[k] == 0 || DC[k] == 0) begin : g_axial
      assign quads_o[k].inner = {4{win_q[C1].px[R1]}};
      assign quads_o[k].outer = {4{win_q[C2].px[R2]}};
    end else begin : g_diag
      // centre, both axial neighbours and the corner
      assign quads_o[k].inner = {win_q[C].px[C],  win_q[C].px[R1],
                                 win_q[C1].px[C], win_q[C1].px[R1]};
      // 2x2 block at offsets 1 and 2
      assign quads_o[k].outer = {win_q[C1].px[R1], win_q[C1].px[R2],
                                 win_q[C2].px[R1], win_q[C2].px[R2]};
    end
  end

endmodule

//--- verilog/ring_bit_unit.sv
module ring_bit_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ni_rd_pkg::dir_quads_t quads_i,
  input  ni_rd_pkg::patch_sum_t sum_i,
  input  logic                  sample_valid_i,
  output logic                  ni_bit_o,
  output logic                  rd_bit_o,
  output logic                  bit_valid_o
);
  import ni_rd_pkg::*;

  pixel_t     inner_avg;
  pixel_t     outer_avg;
  patch_sum_t outer_scaled;

  // floor of the mean of four pixels
  function automatic pixel_t quad_avg(input pixel_t [3:0] q);
    logic [9:0] s;
    s = 10'(q[0]) + 10'(q[1]) + 10'(q[2]) + 10'(q[3]);
    return s[9:2];
  endfunction

  assign inner_avg = quad_avg(quads_i.inner);
  assign outer_avg = quad_avg(quads_i.outer);

  // compare against the patch mean without a divider
  assign outer_scaled = patch_sum_t'(outer_avg) * PATCH_AREA;

  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      ni_bit_o <= (outer_scaled >= sum_i);
      rd_bit_o <= (outer_avg >= inner_avg);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_valid_o <= 1'b0;
    end else begin
      bit_valid_o <= sample_valid_i;
    end
  end

endmodule

//--- verilog/riu2_encoder.sv
module riu2_encoder (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [ni_rd_pkg::NUM_DIR-1:0]   ni_bits_i,
  input  logic [ni_rd_pkg::NUM_DIR-1:0]   rd_bits_i,
  input  logic                            bit_valid_i,
  output ni_rd_pkg::riu2_code_t           ni_o,
  output ni_rd_pkg::riu2_code_t           rd_o,
  output logic                            valid_o
);
  import ni_rd_pkg::*;

  riu2_code_t ni_code;
  riu2_code_t rd_code;

  // uniform patterns map to their ones count, the rest to one bin
  function automatic riu2_code_t riu2_map(input logic [NUM_DIR-1:0] p);
    logic [3:0] trans;
    logic [3:0] ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < NUM_DIR; k++) begin
      // circular neighbour, bit 7 wraps to bit 0
      trans = trans + 4'(p[k] ^ p[(k + 1) % NUM_DIR]);
      ones  = ones + 4'(p[k]);
    end
    return (trans <= 4'd2) ? ones : RIU2_NONUNIFORM;
  endfunction

  assign ni_code = riu2_map(ni_bits_i);
  assign rd_code = riu2_map(rd_bits_i);

  always_ff @(posedge clk) begin
    if (bit_valid_i) begin
      ni_o <= ni_code;
      rd_o <= rd_code;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= bit_valid_i;
    end
  end

endmodule

//--- verilog/ni_rd_top.sv
module ni_rd_top #(
  parameter int IMG_W = 8,
  parameter int IMG_H = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ni_rd_pkg::pixel_t     pixel_i,
  input  logic                  pixel_valid_i,
  output ni_rd_pkg::riu2_code_t ni_o,
  output ni_rd_pkg::riu2_code_t rd_o,
  output logic                  valid_o
);
  import ni_rd_pkg::*;

  win_col_t             col;
  logic                 col_valid;
  logic                 win_full;
  dir_quads_t           quads [NUM_DIR];
  patch_sum_t           patch_sum;
  logic                 sample_valid;
  logic [NUM_DIR-1:0]   ni_bits;
  logic [NUM_DIR-1:0]   rd_bits;
  logic [NUM_DIR-1:0]   bit_valid;

  line_buffer #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) u_line_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .col_o         (col),
    .col_valid_o   (col_valid),
    .win_full_o    (win_full)
  );

  window_sampler u_window_sampler (
    .clk            (clk),
    .rst_n          (rst_n),
    .col_i          (col),
    .col_valid_i    (col_valid),
    .win_full_i     (win_full),
    .quads_o        (quads),
    .sum_o          (patch_sum),
    .sample_valid_o (sample_valid)
  );

  ////////////////////
  // one compare unit per ring direction
  for (genvar k = 0; k < NUM_DIR; k++) begin : g_ring
    ring_bit_unit u_ring_bit_unit (
      .clk            (clk),
      .rst_n          (rst_n),
      .quads_i        (quads[k]),
      .sum_i          (patch_sum),
      .sample_valid_i (sample_valid),
      .ni_bit_o       (ni_bits[k]),
      .rd_bit_o       (rd_bits[k]),
      .bit_valid_o    (bit_valid[k])
    );
  end

  // all units run in lockstep, unit 0 stands for the rest
  riu2_encoder u_riu2_encoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .ni_bits_i   (ni_bits),
    .rd_bits_i   (rd_bits),
    .bit_valid_i (bit_valid[0]),
    .ni_o        (ni_o),
    .rd_o        (rd_o),
    .valid_o     (valid_o)
  );

endmodule

//--- tb/ni_rd_chk.sv
module ni_rd_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  pixel_valid_i,
  input ni_rd_pkg::riu2_code_t ni_o,
  input ni_rd_pkg::riu2_code_t rd_o,
  input logic                  valid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  a_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !valid_o)
    else $error("valid_o high during reset");

  a_code_range: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> (ni_o <= 4'd9 && rd_o <= 4'd9))
    else $error("riu2 code out of range");

  // four register stages between the accepted pixel and valid_o
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> $past(pixel_valid_i, 4))
    else $error("valid_o without a pixel 4 cycles earlier");

endmodule

bind ni_rd_top ni_rd_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .pixel_valid_i (pixel_valid_i),
  .ni_o          (ni_o),
  .rd_o          (rd_o),
  .valid_o       (valid_o)
);

//--- tb/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ni_rd_pkg::*;

  localparam int IMG_W     = 8;
  localparam int IMG_H     = 8;
  localparam int NPIX      = IMG_W * IMG_H;
  localparam int NOUT      = (IMG_W - 4) * (IMG_H - 4);
  // frames played over the whole run
  localparam int RUN_FRAMES = 6;
  localparam int TIMEOUT    = 4 * RUN_FRAMES * NPIX + 100;

  logic       clk;
  logic       rst_n;
  pixel_t     pixel_i;
  logic       pixel_valid_i;
  riu2_code_t ni_o;
  riu2_code_t rd_o;
  logic       valid_o;

  pixel_t     frame_pix [2][NPIX];
  riu2_code_t frame_ni  [2][NOUT];
  riu2_code_t frame_rd  [2][NOUT];

  int         cycle;
  int         out_count;
  int         seed;
  string      test_name;
  int         due_q [$];
  riu2_code_t ni_q  [$];
  riu2_code_t rd_q  [$];

  ni_rd_top #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .pixel_i       (pixel_i),
    .pixel_valid_i (pixel_valid_i),
    .ni_o          (ni_o),
    .rd_o          (rd_o),
    .valid_o       (valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT) begin
      $display("timeout after %0d cycles, outputs still missing", cycle);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // output checks, sampled away from the rising edge
  always @(negedge clk) begin : output_monitor
    int         due;
    riu2_code_t eni;
    riu2_code_t erd;
    if (rst_n && valid_o) begin
      assert (due_q.size() > 0)
        else stop_on_error("valid_o rose with no interior pixel in flight");
      due = due_q.pop_front();
      eni = ni_q.pop_front();
      erd = rd_q.pop_front();
      assert (cycle == due)
        else stop_on_error($sformatf("error %s: expected output at cycle %0d, actual %0d",
                                     test_name, due, cycle));
      assert (ni_o == eni && rd_o == erd)
        else stop_on_error($sformatf("error %s: expected ni=%0d rd=%0d, actual ni=%0d rd=%0d",
                                     test_name, eni, erd, ni_o, rd_o));
      out_count++;
    end
  end

  task automatic read_trace();
    int    fd;
    int    n;
    int    rows;
    int    ecnt;
    int    a;
    int    b;
    int    v [8];
    string line;
    rows = 0;
    ecnt = 0;
    fd = $fopen("tb/ni_rd_trace.txt", "r");
    assert (fd != 0) else stop_on_error("cannot open tb/ni_rd_trace.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) == "p") begin
        n = $sscanf(line, "p %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        for (int j = 0; j < IMG_W; j++) begin
          frame_pix[rows / IMG_H][(rows % IMG_H) * IMG_W + j] = pixel_t'(v[j]);
        end
        rows++;
      end else if (n > 0 && line.getc(0) == "e") begin
        n = $sscanf(line, "e %d %d", a, b);
        frame_ni[ecnt / NOUT][ecnt % NOUT] = riu2_code_t'(a);
        frame_rd[ecnt / NOUT][ecnt % NOUT] = riu2_code_t'(b);
        ecnt++;
      end
    end
    $fclose(fd);
    assert (rows == 2 * IMG_H && ecnt == 2 * NOUT)
      else stop_on_error("trace file does not hold two complete frames");
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    pixel_valid_i = 1'b0;
  endtask

  // interior pixels queue their codes, valid_o due 4 cycles after the pixel
  task automatic play_frame(input int f, input bit gaps);
    int row;
    int col;
    int n;
    for (int i = 0; i < NPIX; i++) begin
      if (gaps) begin
        n = $random(seed) & 3;
        repeat (n) idle_cycle();
      end
      row = i / IMG_W;
      col = i % IMG_W;
      @(posedge clk);
      #1;
      pixel_i       = frame_pix[f][i];
      pixel_valid_i = 1'b1;
      if (row >= 4 && col >= 4) begin
        due_q.push_back(cycle + 4);
        ni_q.push_back(frame_ni[f][(row - 4) * (IMG_W - 4) + col - 4]);
        rd_q.push_back(frame_rd[f][(row - 4) * (IMG_W - 4) + col - 4]);
      end
    end
  endtask

  task automatic finish_test(input int expected);
    idle_cycle();
    while (due_q.size() > 0) begin
      @(posedge clk);
    end
    repeat (6) @(posedge clk);
    assert (out_count == expected)
      else stop_on_error($sformatf("error %s: expected %0d outputs, actual %0d",
                                   test_name, expected, out_count));
    out_count = 0;
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    cycle         = 0;
    out_count     = 0;
    seed          = 32'h5fdd1f6c;
    test_name     = "reset_idle";
    read_trace();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // nothing may come out without pixels
    repeat (10) idle_cycle();
    finish_test(0);

    test_name = "frame_a";
    play_frame(0, 1'b0);
    finish_test(NOUT);

    test_name = "frame_b_flat";
    play_frame(1, 1'b0);
    finish_test(NOUT);

    test_name = "frame_a_gaps";
    play_frame(0, 1'b1);
    finish_test(NOUT);

    test_name = "frames_a_b_a";
    play_frame(0, 1'b0);
    play_frame(1, 1'b0);
    play_frame(0, 1'b0);
    finish_test(3 * NOUT);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- tb/ni_rd_trace.txt
# p: one image row of 8 hex pixels; e: expected NI and RD code (decimal)
# per frame 8 p lines, then 16 e lines for the interior pixels in raster order
p 28 34 40 4c 58 64 70 7c
p 30 3c 48 54 60 6c 78 84
p 38 44 50 5c 68 74 80 8c
p 40 4c 58 64 70 7c 88 94
p 48 54 60 6c 78 84 90 9c
p 50 5c 68 74 80 8c 98 a4
p 58 64 70 7c 88 94 a0 ac
p 60 6c 78 84 90 9c a8 b4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
e 4 4
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
p 80 80 80 80 80 80 80 80
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8
e 8 8

//--- tb.f
verilog/ni_rd_pkg.sv
verilog/line_buffer.sv
verilog/window_sampler.sv
verilog/ring_bit_unit.sv
verilog/riu2_encoder.sv
verilog/ni_rd_top.sv
tb/ni_rd_chk.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
